//--- logic/cache_dma_pkg.sv
// --------------------
// cache dma package
// block geometry, address field widths and the
// controller state encoding
// --------------------

package cache_dma_pkg;

  // address and word widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int BYTE_OFFSET_WIDTH = 2;

  // block geometry
  localparam int BLOCK_WORDS = 8;
  localparam int LG_BLOCK_WORDS = 3;
  localparam int LG_SETS = 4;

  // one data array row per word of every set
  localparam int MEM_ADDR_WIDTH = LG_SETS + LG_BLOCK_WORDS;

  typedef enum logic [2:0] {
    IDLE,
    SEND_FILL_ADDR,
    SEND_EVICT_ADDR,
    GET_FILL_DATA,
    SEND_EVICT_DATA
  } dma_state_e;

endpackage

//--- logic/dma_fill_fifo.sv
// --------------------
// dma fill fifo
// holds one whole block of inbound fill words,
// valid/ready in and valid/yumi out
// --------------------

module dma_fill_fifo (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [cache_dma_pkg::DATA_WIDTH-1:0] data_i,
  input  logic                                v_i,
  output logic                                ready_o,
  output logic                                v_o,
  output logic [cache_dma_pkg::DATA_WIDTH-1:0] data_o,
  input  logic                                yumi_i
);

  logic [cache_dma_pkg::DATA_WIDTH-1:0] mem_r [cache_dma_pkg::BLOCK_WORDS];
  logic [cache_dma_pkg::LG_BLOCK_WORDS-1:0] wr_ptr_r;
  logic [cache_dma_pkg::LG_BLOCK_WORDS-1:0] rd_ptr_r;
  logic [cache_dma_pkg::LG_BLOCK_WORDS:0] count_r;
  logic push;
  logic pop;

  // count only reaches BLOCK_WORDS when full
  assign ready_o = ~count_r[cache_dma_pkg::LG_BLOCK_WORDS];
  assign v_o = |count_r;
  assign data_o = mem_r[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10: count_r <= count_r + 1'b1;
        2'b01: count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

//--- logic/dma_evict_fifo.sv
// --------------------
// dma evict fifo
// two-entry outbound buffer for evicted words
// --------------------

module dma_evict_fifo (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [cache_dma_pkg::DATA_WIDTH-1:0] data_i,
  input  logic                                v_i,
  output logic                                ready_o,
  output logic                                v_o,
  output logic [cache_dma_pkg::DATA_WIDTH-1:0] data_o,
  input  logic                                yumi_i
);

  logic [cache_dma_pkg::DATA_WIDTH-1:0] mem_r [2];
  logic head_r;
  logic tail_r;
  logic full_r;
  logic empty_r;
  logic push;
  logic pop;

  assign push = v_i & ~full_r;
  assign pop = yumi_i & ~empty_r;

  // the read behind ready lands one cycle later, so leave room
  // for a push already on its way in
  assign ready_o = ~full_r & ~(v_i & ~empty_r & ~pop);
  assign v_o = ~empty_r;
  assign data_o = mem_r[head_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_r <= 1'b0;
      tail_r <= 1'b0;
      full_r <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      if (push) begin
        tail_r <= ~tail_r;
      end
      if (pop) begin
        head_r <= ~head_r;
      end
      if (push & ~pop) begin
        empty_r <= 1'b0;
        full_r <= ~empty_r;
      end else if (pop & ~push) begin
        full_r <= 1'b0;
        empty_r <= ~full_r;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[tail_r] <= data_i;
    end
  end

endmodule

//--- logic/cache_dma_ctrl.sv
// --------------------
// cache dma controller
// sequences address packets, fill writes and evict reads
// against the data array, captures the snoop word
// --------------------

module cache_dma_ctrl (
  input  logic clk_i,
  input  logic reset_i,

  input  logic send_fill_addr_i,
  input  logic send_evict_addr_i,
  input  logic get_fill_data_i,
  input  logic send_evict_data_i,
  input  logic way_i,
  input  logic [cache_dma_pkg::ADDR_WIDTH-1:0] addr_i,

  output logic done_o,
  output logic [cache_dma_pkg::DATA_WIDTH-1:0] snoop_word_o,

  output logic [cache_dma_pkg::ADDR_WIDTH-1:0] pkt_addr_o,
  output logic pkt_write_o,
  output logic pkt_v_o,
  input  logic pkt_yumi_i,

  input  logic fill_v_i,
  input  logic [cache_dma_pkg::DATA_WIDTH-1:0] fill_data_i,
  output logic fill_yumi_o,

  input  logic evict_ready_i,
  output logic evict_v_o,

  output logic mem_v_o,
  output logic mem_w_o,
  output logic [cache_dma_pkg::MEM_ADDR_WIDTH-1:0] mem_addr_o,
  output logic [2*(cache_dma_pkg::DATA_WIDTH/8)-1:0] mem_w_mask_o,
  output logic [2*cache_dma_pkg::DATA_WIDTH-1:0] mem_wdata_o
);

  cache_dma_pkg::dma_state_e state_r;
  cache_dma_pkg::dma_state_e state_n;

  logic [cache_dma_pkg::LG_BLOCK_WORDS:0] counter_r;
  logic [cache_dma_pkg::LG_BLOCK_WORDS:0] counter_n;
  logic evict_v_r;
  logic evict_v_n;

  logic [cache_dma_pkg::LG_BLOCK_WORDS-1:0] word_offset;
  logic [cache_dma_pkg::LG_SETS-1:0] set_index;
  logic [cache_dma_pkg::LG_BLOCK_WORDS-1:0] row_word;
  logic last_fill_word;
  logic evict_start;
  logic evict_rd;
  logic snoop_we;

  assign word_offset = addr_i[cache_dma_pkg::BYTE_OFFSET_WIDTH +: cache_dma_pkg::LG_BLOCK_WORDS];
  assign set_index = addr_i[cache_dma_pkg::BYTE_OFFSET_WIDTH + cache_dma_pkg::LG_BLOCK_WORDS
                            +: cache_dma_pkg::LG_SETS];

  // block aligned, byte and word offsets cleared
  assign pkt_addr_o = {
    addr_i[cache_dma_pkg::ADDR_WIDTH-1:cache_dma_pkg::BYTE_OFFSET_WIDTH
           + cache_dma_pkg::LG_BLOCK_WORDS],
    {(cache_dma_pkg::BYTE_OFFSET_WIDTH + cache_dma_pkg::LG_BLOCK_WORDS){1'b0}}
  };
  assign pkt_write_o = (state_r == cache_dma_pkg::SEND_EVICT_ADDR);

  // row 0 is read straight out of idle
  assign row_word = (state_r == cache_dma_pkg::IDLE)
    ? '0
    : counter_r[cache_dma_pkg::LG_BLOCK_WORDS-1:0];
  assign mem_addr_o = {set_index, row_word};

  // way 1 in the upper half
  assign mem_w_mask_o = {
    {(cache_dma_pkg::DATA_WIDTH/8){way_i}},
    {(cache_dma_pkg::DATA_WIDTH/8){~way_i}}
  };
  assign mem_wdata_o = {2{fill_data_i}};

  assign evict_v_o = evict_v_r;

  assign last_fill_word = (counter_r == {1'b0, {cache_dma_pkg::LG_BLOCK_WORDS{1'b1}}});
  assign evict_start = ~send_fill_addr_i & ~send_evict_addr_i & ~get_fill_data_i
    & send_evict_data_i & evict_ready_i;
  assign evict_rd = evict_ready_i & ~counter_r[cache_dma_pkg::LG_BLOCK_WORDS];

  always_comb begin
    state_n = state_r;
    counter_n = counter_r;
    evict_v_n = 1'b0;
    done_o = 1'b0;
    pkt_v_o = 1'b0;
    fill_yumi_o = 1'b0;
    mem_v_o = 1'b0;
    mem_w_o = 1'b0;

    case (state_r)
      cache_dma_pkg::IDLE: begin
        if (send_fill_addr_i) begin
          state_n = cache_dma_pkg::SEND_FILL_ADDR;
        end else if (send_evict_addr_i) begin
          state_n = cache_dma_pkg::SEND_EVICT_ADDR;
        end else if (get_fill_data_i) begin
          state_n = cache_dma_pkg::GET_FILL_DATA;
          counter_n = '0;
        end else if (evict_start) begin
          state_n = cache_dma_pkg::SEND_EVICT_DATA;
          counter_n = 1;
          mem_v_o = 1'b1;
          evict_v_n = 1'b1;
        end
      end

      cache_dma_pkg::SEND_FILL_ADDR,
      cache_dma_pkg::SEND_EVICT_ADDR: begin
        pkt_v_o = 1'b1;
        done_o = pkt_yumi_i;
        if (pkt_yumi_i) begin
          state_n = cache_dma_pkg::IDLE;
        end
      end

      cache_dma_pkg::GET_FILL_DATA: begin
        mem_v_o = fill_v_i;
        mem_w_o = fill_v_i;
        fill_yumi_o = fill_v_i;
        if (fill_v_i) begin
          counter_n = counter_r + 1'b1;
        end
        done_o = fill_v_i & last_fill_word;
        if (fill_v_i & last_fill_word) begin
          state_n = cache_dma_pkg::IDLE;
        end
      end

      cache_dma_pkg::SEND_EVICT_DATA: begin
        mem_v_o = evict_rd;
        evict_v_n = evict_rd;
        if (evict_rd) begin
          counter_n = counter_r + 1'b1;
        end
        // all rows read, finish once the buffer has room
        done_o = counter_r[cache_dma_pkg::LG_BLOCK_WORDS] & evict_ready_i;
        if (counter_r[cache_dma_pkg::LG_BLOCK_WORDS] & evict_ready_i) begin
          state_n = cache_dma_pkg::IDLE;
        end
      end

      default: begin
        state_n = cache_dma_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cache_dma_pkg::IDLE;
      counter_r <= '0;
      evict_v_r <= 1'b0;
    end else begin
      state_r <= state_n;
      counter_r <= counter_n;
      evict_v_r <= evict_v_n;
    end
  end

  // keep the word the cache missed on
  assign snoop_we = (state_r == cache_dma_pkg::GET_FILL_DATA) & fill_v_i
    & (counter_r[cache_dma_pkg::LG_BLOCK_WORDS-1:0] == word_offset);

  always_ff @(posedge clk_i) begin
    if (snoop_we) begin
      snoop_word_o <= fill_data_i;
    end
  end

endmodule

//--- logic/cache_data_mem.sv
// --------------------
// cache data array
// two ways side by side in each row, byte write mask,
// registered read port
// --------------------

module cache_data_mem (
  input  logic clk_i,
  input  logic v_i,
  input  logic w_i,
  input  logic [cache_dma_pkg::MEM_ADDR_WIDTH-1:0] addr_i,
  input  logic [2*(cache_dma_pkg::DATA_WIDTH/8)-1:0] w_mask_i,
  input  logic [2*cache_dma_pkg::DATA_WIDTH-1:0] data_i,
  output logic [2*cache_dma_pkg::DATA_WIDTH-1:0] data_o
);

  logic [2*cache_dma_pkg::DATA_WIDTH-1:0] mem_r [2**cache_dma_pkg::MEM_ADDR_WIDTH];

  // byte lanes written one by one
  always_ff @(posedge clk_i) begin
    if (v_i & w_i) begin
      for (int i = 0; i < 2*(cache_dma_pkg::DATA_WIDTH/8); i++) begin
        if (w_mask_i[i]) begin
          mem_r[addr_i][8*i +: 8] <= data_i[8*i +: 8];
        end
      end
    end
  end

  // read data shows up the cycle after the request
  always_ff @(posedge clk_i) begin
    if (v_i & ~w_i) begin
      data_o <= mem_r[addr_i];
    end
  end

endmodule

//--- logic/cache_dma_top.sv
// --------------------
// cache dma top
// controller, fill and evict buffers and data array
// --------------------

module cache_dma_top (
  input  logic clk_i,
  input  logic reset_i,

  input  logic send_fill_addr_i,
  input  logic send_evict_addr_i,
  input  logic get_fill_data_i,
  input  logic send_evict_data_i,
  input  logic dma_way_i,
  input  logic [cache_dma_pkg::ADDR_WIDTH-1:0] dma_addr_i,

  output logic done_o,
  output logic [cache_dma_pkg::DATA_WIDTH-1:0] snoop_word_o,

  output logic [cache_dma_pkg::ADDR_WIDTH-1:0] dma_pkt_addr_o,
  output logic dma_pkt_write_o,
  output logic dma_pkt_v_o,
  input  logic dma_pkt_yumi_i,

  input  logic [cache_dma_pkg::DATA_WIDTH-1:0] dma_data_i,
  input  logic dma_data_v_i,
  output logic dma_data_ready_o,

  output logic [cache_dma_pkg::DATA_WIDTH-1:0] dma_data_o,
  output logic dma_data_v_o,
  input  logic dma_data_yumi_i
);

  logic fill_v;
  logic [cache_dma_pkg::DATA_WIDTH-1:0] fill_data;
  logic fill_yumi;

  logic evict_v;
  logic evict_ready;
  logic [cache_dma_pkg::DATA_WIDTH-1:0] evict_data;

  logic mem_v;
  logic mem_w;
  logic [cache_dma_pkg::MEM_ADDR_WIDTH-1:0] mem_addr;
  logic [2*(cache_dma_pkg::DATA_WIDTH/8)-1:0] mem_w_mask;
  logic [2*cache_dma_pkg::DATA_WIDTH-1:0] mem_wdata;
  logic [2*cache_dma_pkg::DATA_WIDTH-1:0] mem_rdata;

  // way half of the read row
  assign evict_data = dma_way_i
    ? mem_rdata[cache_dma_pkg::DATA_WIDTH +: cache_dma_pkg::DATA_WIDTH]
    : mem_rdata[0 +: cache_dma_pkg::DATA_WIDTH];

  cache_dma_ctrl ctrl (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .send_fill_addr_i  (send_fill_addr_i),
    .send_evict_addr_i (send_evict_addr_i),
    .get_fill_data_i   (get_fill_data_i),
    .send_evict_data_i (send_evict_data_i),
    .way_i             (dma_way_i),
    .addr_i            (dma_addr_i),
    .done_o            (done_o),
    .snoop_word_o      (snoop_word_o),
    .pkt_addr_o        (dma_pkt_addr_o),
    .pkt_write_o       (dma_pkt_write_o),
    .pkt_v_o           (dma_pkt_v_o),
    .pkt_yumi_i        (dma_pkt_yumi_i),
    .fill_v_i          (fill_v),
    .fill_data_i       (fill_data),
    .fill_yumi_o       (fill_yumi),
    .evict_ready_i     (evict_ready),
    .evict_v_o         (evict_v),
    .mem_v_o           (mem_v),
    .mem_w_o           (mem_w),
    .mem_addr_o        (mem_addr),
    .mem_w_mask_o      (mem_w_mask),
    .mem_wdata_o       (mem_wdata)
  );

  dma_fill_fifo fill_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (dma_data_i),
    .v_i     (dma_data_v_i),
    .ready_o (dma_data_ready_o),
    .v_o     (fill_v),
    .data_o  (fill_data),
    .yumi_i  (fill_yumi)
  );

  dma_evict_fifo evict_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (evict_data),
    .v_i     (evict_v),
    .ready_o (evict_ready),
    .v_o     (dma_data_v_o),
    .data_o  (dma_data_o),
    .yumi_i  (dma_data_yumi_i)
  );

  cache_data_mem data_mem (
    .clk_i    (clk_i),
    .v_i      (mem_v),
    .w_i      (mem_w),
    .addr_i   (mem_addr),
    .w_mask_i (mem_w_mask),
    .data_i   (mem_wdata),
    .data_o   (mem_rdata)
  );

endmodule

//--- dv/cache_dma_assertions.sv
// --------------------
// cache dma assertions
// handshake rules on the memory side ports
// --------------------

module cache_dma_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic done_o,
  input logic [cache_dma_pkg::ADDR_WIDTH-1:0] dma_pkt_addr_o,
  input logic dma_pkt_write_o,
  input logic dma_pkt_v_o,
  input logic dma_pkt_yumi_i,
  input logic [cache_dma_pkg::DATA_WIDTH-1:0] dma_data_o,
  input logic dma_data_v_o,
  input logic dma_data_yumi_i
);

  int fail_count = 0;

  // packet stays offered until taken
  pkt_held: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_pkt_v_o && !dma_pkt_yumi_i |=>
      dma_pkt_v_o && $stable(dma_pkt_addr_o) && $stable(dma_pkt_write_o))
  else begin
    fail_count++;
    $error("packet valid dropped or changed before yumi");
  end

  data_held: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_data_v_o && !dma_data_yumi_i |=> dma_data_v_o && $stable(dma_data_o))
  else begin
    fail_count++;
    $error("outbound valid dropped or changed before yumi");
  end

  pkt_yumi_with_v: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_pkt_yumi_i |-> dma_pkt_v_o)
  else begin
    fail_count++;
    $error("packet yumi raised without valid");
  end

  data_yumi_with_v: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_data_yumi_i |-> dma_data_v_o)
  else begin
    fail_count++;
    $error("outbound yumi raised without valid");
  end

  done_single: assert property (@(posedge clk_i) disable iff (reset_i)
    done_o |=> !done_o)
  else begin
    fail_count++;
    $error("done held for two cycles");
  end

endmodule

bind cache_dma_top cache_dma_assertions u_assertions (.*);

//--- dv/cache_dma_tb.sv
// --------------------
// cache dma testbench
// random fills, evicts and address packets under
// random stalls, checked against a line model
// --------------------

module cache_dma_tb;

  localparam int NUM_TRANS = 40;
  localparam int CYCLE_LIMIT = NUM_TRANS * 200;
  localparam int WORDS = cache_dma_pkg::BLOCK_WORDS;

  logic clk_i = 1'b0;
  logic reset_i;
  logic send_fill_addr_i;
  logic send_evict_addr_i;
  logic get_fill_data_i;
  logic send_evict_data_i;
  logic dma_way_i;
  logic [31:0] dma_addr_i;
  logic done_o;
  logic [31:0] snoop_word_o;
  logic [31:0] dma_pkt_addr_o;
  logic dma_pkt_write_o;
  logic dma_pkt_v_o;
  logic dma_pkt_yumi_i;
  logic [31:0] dma_data_i;
  logic dma_data_v_i;
  logic dma_data_ready_o;
  logic [31:0] dma_data_o;
  logic dma_data_v_o;
  logic dma_data_yumi_i;

  logic [31:0] rng_state;
  int cycle_count;
  int error_count;
  int check_count;
  logic [31:0] in_q [$];
  logic [31:0] out_q [$];
  logic [31:0] pkt_addr_q [$];
  logic pkt_write_q [$];
  // model lines by way, set and word
  logic [31:0] model_mem [2][4][WORDS];
  logic filled [2][4];

  cache_dma_top UUT (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic coin_flip();
    logic [31:0] r;
    r = draw_random();
    return r[9];
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("ERROR at %0t: %s", $time, what);
    end
  endtask

  // one clock of the memory-side responders and monitors
  task automatic step_cycle();
    logic pkt_coin;
    logic in_coin;
    logic out_coin;
    @(posedge clk_i);
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      error_count++;
      $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
      $display("checks %0d, errors %0d", check_count, error_count);
      $display("test failed");
      $finish;
    end
    pkt_coin = coin_flip();
    in_coin = coin_flip();
    out_coin = coin_flip();
    if (dma_pkt_v_o && dma_pkt_yumi_i) begin
      expect_true(done_o, "done_o low in the packet handshake cycle");
      pkt_addr_q.push_back(dma_pkt_addr_o);
      pkt_write_q.push_back(dma_pkt_write_o);
    end
    // valid stays up next cycle only when nothing was taken now
    dma_pkt_yumi_i <= dma_pkt_v_o && !dma_pkt_yumi_i && pkt_coin;
    if (dma_data_v_i && dma_data_ready_o) begin
      void'(in_q.pop_front());
    end
    if (in_q.size() > 0 && in_coin) begin
      dma_data_v_i <= 1'b1;
      dma_data_i <= in_q[0];
    end else begin
      dma_data_v_i <= 1'b0;
    end
    if (dma_data_v_o && dma_data_yumi_i) begin
      out_q.push_back(dma_data_o);
    end
    dma_data_yumi_i <= dma_data_v_o && !dma_data_yumi_i && out_coin;
  endtask

  // op 0 fill address, 1 evict address, 2 fill data, 3 evict data
  task automatic run_request(input int op, input logic way, input logic [31:0] addr);
    logic [31:0] words [WORDS];
    logic [1:0] set;
    logic [2:0] offset;
    set = addr[6:5];
    offset = addr[4:2];
    step_cycle();
    if (op == 2) begin
      for (int i = 0; i < WORDS; i++) begin
        words[i] = draw_random();
        in_q.push_back(words[i]);
      end
    end
    dma_way_i <= way;
    dma_addr_i <= addr;
    send_fill_addr_i <= (op == 0);
    send_evict_addr_i <= (op == 1);
    get_fill_data_i <= (op == 2);
    send_evict_data_i <= (op == 3);
    do begin
      step_cycle();
    end while (!done_o);
    if (op < 2) begin
      expect_true(pkt_addr_q.size() == 1, "done_o raised before the packet handshake");
    end
    send_fill_addr_i <= 1'b0;
    send_evict_addr_i <= 1'b0;
    get_fill_data_i <= 1'b0;
    send_evict_data_i <= 1'b0;
    step_cycle();
    if (op < 2) begin
      expect_true(pkt_addr_q.size() == 1, "address request did not send exactly one packet");
      if (pkt_addr_q.size() == 1) begin
        compare_word("dma_pkt_addr_o", pkt_addr_q[0], {addr[31:5], 5'b0});
        compare_word("dma_pkt_write_o", {31'b0, pkt_write_q[0]}, {31'b0, op == 1});
      end
    end else begin
      expect_true(pkt_addr_q.size() == 0, "packet sent during a data transfer");
    end
    pkt_addr_q.delete();
    pkt_write_q.delete();
    if (op == 3) begin
      while (out_q.size() < WORDS) begin
        step_cycle();
      end
      for (int i = 0; i < WORDS; i++) begin
        compare_word($sformatf("dma_data_o[%0d]", i), out_q[i], model_mem[way][set][i]);
      end
      out_q.delete();
    end else begin
      expect_true(out_q.size() == 0, "outbound word sent outside an evict");
    end
    if (op == 2) begin
      expect_true(in_q.size() == 0, "fill finished before all words were taken");
      compare_word("snoop_word_o", snoop_word_o, words[offset]);
      for (int i = 0; i < WORDS; i++) begin
        model_mem[way][set][i] = words[i];
      end
      filled[way][set] = 1'b1;
    end
  endtask

  initial begin
    int op;
    int total;
    logic [31:0] r;
    logic [31:0] addr;
    rng_state = 32'hd5b0;
    cycle_count = 0;
    error_count = 0;
    check_count = 0;
    reset_i = 1'b1;
    send_fill_addr_i = 1'b0;
    send_evict_addr_i = 1'b0;
    get_fill_data_i = 1'b0;
    send_evict_data_i = 1'b0;
    dma_way_i = 1'b0;
    dma_addr_i = '0;
    dma_pkt_yumi_i = 1'b0;
    dma_data_i = '0;
    dma_data_v_i = 1'b0;
    dma_data_yumi_i = 1'b0;
    foreach (filled[w, s]) begin
      filled[w][s] = 1'b0;
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    repeat (4) begin
      step_cycle();
      expect_true(!done_o && !dma_pkt_v_o && !dma_data_v_o, "outputs active with no request");
      expect_true(dma_data_ready_o, "fill buffer not ready after reset");
    end

    for (int n = 0; n < NUM_TRANS; n++) begin
      r = draw_random();
      op = r[5:4];
      addr = draw_random();
      addr[8:5] = {2'b00, r[2:1]};
      // evict only lines that hold data
      if (op == 3 && !filled[r[0]][r[2:1]]) begin
        op = 2;
      end
      run_request(op, r[0], addr);
    end

    repeat (10) step_cycle();
    expect_true(out_q.size() == 0 && pkt_addr_q.size() == 0, "traffic after the last request");
    total = error_count + UUT.u_assertions.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
             UUT.u_assertions.fail_count);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- cache_dma.f
logic/cache_dma_pkg.sv
logic/dma_fill_fifo.sv
logic/dma_evict_fifo.sv
logic/cache_dma_ctrl.sv
logic/cache_data_mem.sv
logic/cache_dma_top.sv
dv/cache_dma_assertions.sv
dv/cache_dma_tb.sv

//--- Bender.yml
package:
  name: cache_dma

sources:
  - logic/cache_dma_pkg.sv
  - logic/dma_fill_fifo.sv
  - logic/dma_evict_fifo.sv
  - logic/cache_dma_ctrl.sv
  - logic/cache_data_mem.sv
  - logic/cache_dma_top.sv
  - target: test
    files:
      - dv/cache_dma_assertions.sv
      - dv/cache_dma_tb.sv
